//--- source/rv32i_types.sv
package rv32i_types;

typedef logic [31:0] rv32i_word;
typedef logic [4:0] rv32i_reg;

// major opcodes of the base integer set.
typedef enum logic [6:0] {
	op_lui   = 7'b0110111,
	op_auipc = 7'b0010111,
	op_jal   = 7'b1101111,
	op_jalr  = 7'b1100111,
	op_br    = 7'b1100011,
	op_load  = 7'b0000011,
	op_store = 7'b0100011,
	op_imm   = 7'b0010011,
	op_reg   = 7'b0110011,
	op_csr   = 7'b1110011
} rv32i_opcode;

// funct3 field of OP and OP-IMM instructions.
typedef enum logic [2:0] {
	f3_add  = 3'b000, // add or sub, picked by funct7.
	f3_sll  = 3'b001,
	f3_slt  = 3'b010,
	f3_sltu = 3'b011,
	f3_xor  = 3'b100,
	f3_sr   = 3'b101, // srl or sra, picked by funct7.
	f3_or   = 3'b110,
	f3_and  = 3'b111
} arith_funct3_t;

typedef enum logic [3:0] {
	add, sub, sll, slt, sltu, axor, srl, sra, aor, aand
} alu_ops;

endpackage : rv32i_types

//--- source/circular_q.sv
`timescale 1ns/1ps

module circular_q import rv32i_types::*; #(
	parameter int iq_depth = 4,
	localparam int ptr_w = (iq_depth > 1) ? $clog2(iq_depth) : 1,
	localparam int cnt_w = $clog2(iq_depth + 1)
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	output logic      in_ready,
	input  rv32i_word in_data,
	output logic      out_valid,
	input  logic      out_ready,
	output rv32i_word out_data
);

	rv32i_word mem [iq_depth];
	logic [ptr_w-1:0] head, tail;
	logic [cnt_w-1:0] count;
	logic push, pop;

	assign in_ready = (count != cnt_w'(iq_depth));
	assign out_valid = (count != '0); // the head is always a registered word.
	assign out_data = mem[head];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= (tail == ptr_w'(iq_depth - 1)) ? '0 : tail + 1'b1;
			if (pop)
				head <= (head == ptr_w'(iq_depth - 1)) ? '0 : head + 1'b1;
			count <= count + cnt_w'(push) - cnt_w'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[tail] <= in_data;
	end

	// the occupancy must never run past the ring size.
	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= cnt_w'(iq_depth));

endmodule : circular_q

//--- source/decoder.sv
`timescale 1ns/1ps

module decoder import rv32i_types::*; #(
	parameter int rob_size = 8,
	localparam int tag_w = $clog2(rob_size)
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             q_valid,
	input  rv32i_word        q_data,
	output logic             q_ready,
	output rv32i_reg         rs1,
	output rv32i_reg         rs2,
	input  logic             rs1_busy,
	input  logic             rs2_busy,
	input  logic [tag_w-1:0] rs1_tag,
	input  logic [tag_w-1:0] rs2_tag,
	input  rv32i_word        rs1_value,
	input  rv32i_word        rs2_value,
	input  logic             rob_full,
	input  logic [tag_w-1:0] alloc_tag,
	input  logic             rob_ready1,
	input  logic             rob_ready2,
	input  rv32i_word        rob_value1,
	input  rv32i_word        rob_value2,
	input  logic             rs_full,
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  rv32i_word        cdb_data,
	output logic             dispatch,
	output rv32i_reg         dispatch_rd,
	output alu_ops           dispatch_op,
	output rv32i_word        a_value,
	output rv32i_word        b_value,
	output logic             a_ready,
	output logic             b_ready,
	output logic [tag_w-1:0] a_tag,
	output logic [tag_w-1:0] b_tag
);

	rv32i_opcode opcode;
	arith_funct3_t funct3;
	rv32i_word i_imm, u_imm;

	assign opcode = rv32i_opcode'(q_data[6:0]);
	assign funct3 = arith_funct3_t'(q_data[14:12]);
	assign i_imm = {{20{q_data[31]}}, q_data[31:20]};
	assign u_imm = {q_data[31:12], 12'h000};

	assign rs1 = (opcode == op_lui) ? 5'd0 : q_data[19:15]; // lui adds to x0.
	assign rs2 = q_data[24:20];
	assign a_tag = rs1_tag;
	assign b_tag = rs2_tag;
	assign q_ready = !rob_full && !rs_full;
	assign dispatch = q_valid && q_ready;

	always_comb begin
		a_value = rs1_value;
		a_ready = 1'b1;
		if (rs1_busy) begin
			if (rob_ready1)
				a_value = rob_value1; // finished but not yet retired.
			else if (cdb_valid && cdb_tag == rs1_tag)
				a_value = cdb_data;
			else
				a_ready = 1'b0;
		end
		b_value = rs2_value;
		b_ready = 1'b1;
		if (rs2_busy) begin
			if (rob_ready2)
				b_value = rob_value2;
			else if (cdb_valid && cdb_tag == rs2_tag)
				b_value = cdb_data;
			else
				b_ready = 1'b0;
		end
		dispatch_rd = q_data[11:7];
		dispatch_op = add;
		unique case (funct3)
			f3_add:  dispatch_op = (opcode == op_reg && q_data[30]) ? sub : add;
			f3_sll:  dispatch_op = sll;
			f3_slt:  dispatch_op = slt;
			f3_sltu: dispatch_op = sltu;
			f3_xor:  dispatch_op = axor;
			f3_sr:   dispatch_op = q_data[30] ? sra : srl;
			f3_or:   dispatch_op = aor;
			f3_and:  dispatch_op = aand;
		endcase
		case (opcode)
			op_reg: ;
			op_imm: begin
				b_value = i_imm;
				b_ready = 1'b1;
			end
			op_lui: begin
				dispatch_op = add;
				b_value = u_imm;
				b_ready = 1'b1;
			end
			default: begin
				// anything else retires as a harmless add into x0.
				dispatch_op = add;
				dispatch_rd = 5'd0;
				a_value = '0;
				a_ready = 1'b1;
				b_value = '0;
				b_ready = 1'b1;
			end
		endcase
	end

	// a stalled head word stays put until the decoder takes it.
	a_head_stable: assert property (@(posedge clk) disable iff (reset)
		q_valid && !dispatch |=> q_valid && $stable(q_data));

endmodule : decoder

//--- source/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import rv32i_types::*; #(
	parameter int alu_rs_size = 4,
	parameter int rob_size = 8,
	localparam int tag_w = $clog2(rob_size),
	localparam int idx_w = (alu_rs_size > 1) ? $clog2(alu_rs_size) : 1
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             dispatch,
	input  alu_ops           dispatch_op,
	input  rv32i_word        a_value,
	input  rv32i_word        b_value,
	input  logic             a_ready,
	input  logic             b_ready,
	input  logic [tag_w-1:0] a_tag,
	input  logic [tag_w-1:0] b_tag,
	input  logic [tag_w-1:0] dest_tag,
	output logic             rs_full,
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  rv32i_word        cdb_data,
	output logic             issue_valid,
	input  logic             issue_ready,
	output alu_ops           issue_op,
	output rv32i_word        issue_a,
	output rv32i_word        issue_b,
	output logic [tag_w-1:0] issue_tag
);

	logic [alu_rs_size-1:0] valid, a_rdy, b_rdy;
	alu_ops op [alu_rs_size];
	rv32i_word a_val [alu_rs_size];
	rv32i_word b_val [alu_rs_size];
	logic [tag_w-1:0] a_src [alu_rs_size];
	logic [tag_w-1:0] b_src [alu_rs_size];
	logic [tag_w-1:0] dest [alu_rs_size];
	logic [idx_w-1:0] free_idx, issue_idx;

	assign rs_full = &valid;

	// scan from the top so the lowest index wins both searches.
	always_comb begin
		free_idx = '0;
		issue_idx = '0;
		issue_valid = 1'b0;
		for (int i = alu_rs_size - 1; i >= 0; i--) begin
			if (!valid[i])
				free_idx = idx_w'(i);
			if (valid[i] && a_rdy[i] && b_rdy[i]) begin
				issue_idx = idx_w'(i);
				issue_valid = 1'b1;
			end
		end
	end

	assign issue_op = op[issue_idx];
	assign issue_a = a_val[issue_idx];
	assign issue_b = b_val[issue_idx];
	assign issue_tag = dest[issue_idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			valid <= '0;
			a_rdy <= '0;
			b_rdy <= '0;
		end else begin
			for (int i = 0; i < alu_rs_size; i++) begin
				if (cdb_valid && valid[i] && !a_rdy[i] && a_src[i] == cdb_tag) begin
					a_val[i] <= cdb_data; // snoop the bus for a missing operand.
					a_rdy[i] <= 1'b1;
				end
				if (cdb_valid && valid[i] && !b_rdy[i] && b_src[i] == cdb_tag) begin
					b_val[i] <= cdb_data;
					b_rdy[i] <= 1'b1;
				end
			end
			if (issue_valid && issue_ready)
				valid[issue_idx] <= 1'b0;
			if (dispatch) begin
				valid[free_idx] <= 1'b1;
				op[free_idx] <= dispatch_op;
				a_val[free_idx] <= a_value;
				b_val[free_idx] <= b_value;
				a_rdy[free_idx] <= a_ready;
				b_rdy[free_idx] <= b_ready;
				a_src[free_idx] <= a_tag;
				b_src[free_idx] <= b_tag;
				dest[free_idx] <= dest_tag;
			end
		end
	end

	// a new operation must land in an empty slot, never over one still waiting.
	a_dispatch_free: assert property (@(posedge clk) disable iff (reset)
		dispatch |-> !valid[free_idx]);

endmodule : reservation_station

//--- source/alu.sv
`timescale 1ns/1ps

module alu import rv32i_types::*; #(
	parameter int rob_size = 8,
	localparam int tag_w = $clog2(rob_size)
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             issue_valid,
	output logic             issue_ready,
	input  alu_ops           issue_op,
	input  rv32i_word        issue_a,
	input  rv32i_word        issue_b,
	input  logic [tag_w-1:0] issue_tag,
	output logic             cdb_valid,
	output logic [tag_w-1:0] cdb_tag,
	output rv32i_word        cdb_data
);

	rv32i_word result;
	logic [4:0] shamt;

	// the result register empties every cycle, since the bus never stalls.
	assign issue_ready = 1'b1;
	assign shamt = issue_b[4:0];

	always_comb begin
		unique case (issue_op)
			add:  result = issue_a + issue_b;
			sub:  result = issue_a - issue_b;
			sll:  result = issue_a << shamt;
			slt:  result = {31'd0, $signed(issue_a) < $signed(issue_b)};
			sltu: result = {31'd0, issue_a < issue_b};
			axor: result = issue_a ^ issue_b;
			srl:  result = issue_a >> shamt;
			sra:  result = $unsigned($signed(issue_a) >>> shamt);
			aor:  result = issue_a | issue_b;
			aand: result = issue_a & issue_b;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			cdb_valid <= 1'b0;
		else
			cdb_valid <= issue_valid && issue_ready; // one-cycle broadcast.
	end

	always_ff @(posedge clk) begin
		cdb_tag <= issue_tag;
		cdb_data <= result;
	end

endmodule : alu

//--- source/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer import rv32i_types::*; #(
	parameter int rob_size = 8,
	localparam int tag_w = $clog2(rob_size),
	localparam int cnt_w = $clog2(rob_size + 1)
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             dispatch,
	input  rv32i_reg         dispatch_rd,
	output logic             rob_full,
	output logic [tag_w-1:0] alloc_tag,
	input  logic [tag_w-1:0] query_tag1,
	input  logic [tag_w-1:0] query_tag2,
	output logic             rob_ready1,
	output logic             rob_ready2,
	output rv32i_word        rob_value1,
	output rv32i_word        rob_value2,
	input  logic             cdb_valid,
	input  logic [tag_w-1:0] cdb_tag,
	input  rv32i_word        cdb_data,
	output logic             commit_valid,
	output rv32i_reg         commit_rd,
	output logic [tag_w-1:0] commit_tag,
	output rv32i_word        commit_data
);

	rv32i_reg dest [rob_size];
	rv32i_word value [rob_size];
	logic [rob_size-1:0] done;
	logic [tag_w-1:0] head, tail;
	logic [cnt_w-1:0] count;

	assign rob_full = (count == cnt_w'(rob_size));
	assign alloc_tag = tail; // the tag is simply the slot index.

	// forwarding for operands whose producer already finished.
	assign rob_ready1 = done[query_tag1];
	assign rob_ready2 = done[query_tag2];
	assign rob_value1 = value[query_tag1];
	assign rob_value2 = value[query_tag2];

	assign commit_valid = (count != '0) && done[head];
	assign commit_rd = dest[head];
	assign commit_tag = head;
	assign commit_data = (dest[head] == 5'd0) ? '0 : value[head];

	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done <= '0;
		end else begin
			if (cdb_valid)
				done[cdb_tag] <= 1'b1;
			if (dispatch) begin
				done[tail] <= 1'b0; // a fresh slot waits for its result.
				tail <= (tail == tag_w'(rob_size - 1)) ? '0 : tail + 1'b1;
			end
			if (commit_valid)
				head <= (head == tag_w'(rob_size - 1)) ? '0 : head + 1'b1;
			count <= count + cnt_w'(dispatch) - cnt_w'(commit_valid);
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch)
			dest[tail] <= dispatch_rd;
		if (cdb_valid)
			value[cdb_tag] <= cdb_data;
	end

	// the decoder must hold dispatch off while every slot is taken.
	a_no_alloc_full: assert property (@(posedge clk) disable iff (reset)
		dispatch |-> !rob_full);

endmodule : reorder_buffer

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile import rv32i_types::*; #(
	parameter int rob_size = 8,
	localparam int tag_w = $clog2(rob_size)
) (
	input  logic             clk,
	input  logic             reset,
	input  rv32i_reg         rs1,
	input  rv32i_reg         rs2,
	output rv32i_word        rs1_value,
	output rv32i_word        rs2_value,
	output logic             rs1_busy,
	output logic             rs2_busy,
	output logic [tag_w-1:0] rs1_tag,
	output logic [tag_w-1:0] rs2_tag,
	input  logic             dispatch,
	input  rv32i_reg         dispatch_rd,
	input  logic [tag_w-1:0] alloc_tag,
	input  logic             commit_valid,
	input  rv32i_reg         commit_rd,
	input  logic [tag_w-1:0] commit_tag,
	input  rv32i_word        commit_data
);

	rv32i_word regs [32];
	logic [31:0] busy;
	logic [tag_w-1:0] tags [32];

	assign rs1_value = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_value = (rs2 == 5'd0) ? '0 : regs[rs2];
	assign rs1_busy = busy[rs1]; // x0 is never marked busy.
	assign rs2_busy = busy[rs2];
	assign rs1_tag = tags[rs1];
	assign rs2_tag = tags[rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else begin
			if (commit_valid && commit_rd != 5'd0) begin
				regs[commit_rd] <= commit_data;
				if (tags[commit_rd] == commit_tag)
					busy[commit_rd] <= 1'b0; // only the latest producer frees it.
			end
			if (dispatch && dispatch_rd != 5'd0)
				busy[dispatch_rd] <= 1'b1; // a new rename overrides the clear above.
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch && dispatch_rd != 5'd0)
			tags[dispatch_rd] <= alloc_tag;
	end

endmodule : regfile

//--- source/cpu.sv
`timescale 1ns/1ps

module cpu import rv32i_types::*; #(
	parameter int rob_size = 8,
	parameter int alu_rs_size = 4,
	parameter int iq_depth = 4,
	localparam int tag_w = $clog2(rob_size)
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      instr_valid,
	input  rv32i_word instr,
	output logic      instr_ready,
	output logic      commit_valid,
	output rv32i_reg  commit_rd,
	output rv32i_word commit_data
);

	logic q_valid, q_ready;
	rv32i_word q_data;

	// rename lookup and dispatch.
	rv32i_reg rs1, rs2, dispatch_rd;
	rv32i_word rs1_value, rs2_value, rob_value1, rob_value2;
	logic rs1_busy, rs2_busy, rob_ready1, rob_ready2;
	logic [tag_w-1:0] rs1_tag, rs2_tag, alloc_tag, commit_tag;
	logic rob_full, rs_full, dispatch;
	alu_ops dispatch_op;
	rv32i_word a_value, b_value;
	logic a_ready, b_ready;
	logic [tag_w-1:0] a_tag, b_tag;

	// issue and the common data bus.
	logic issue_valid, issue_ready, cdb_valid;
	alu_ops issue_op;
	rv32i_word issue_a, issue_b, cdb_data;
	logic [tag_w-1:0] issue_tag, cdb_tag;

	circular_q #(.iq_depth(iq_depth)) iq (
		.in_valid(instr_valid), .in_ready(instr_ready), .in_data(instr),
		.out_valid(q_valid), .out_ready(q_ready), .out_data(q_data), .*
	);

	decoder #(.rob_size(rob_size)) decoder (.*);

	reservation_station #(.alu_rs_size(alu_rs_size), .rob_size(rob_size)) alu_rs (
		.dest_tag(alloc_tag), .*
	);

	alu #(.rob_size(rob_size)) alu_module (.*);

	reorder_buffer #(.rob_size(rob_size)) reorder_buffer (
		.query_tag1(rs1_tag), .query_tag2(rs2_tag), .*
	);

	regfile #(.rob_size(rob_size)) registers (.*);

endmodule : cpu

//--- sim/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// architectural state of the reference model, with x0 held at zero.
logic [31:0] model_regs [32];

task automatic clear_model_regs();
	foreach (model_regs[i])
		model_regs[i] = 32'd0;
endtask

// runs one word in program order and returns what it should retire.
task automatic execute_word(input logic [31:0] word, output logic [4:0] rd,
		output logic [31:0] data);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [31:0] a;
	logic [31:0] b;
	logic is_op;
	opcode = word[6:0];
	funct3 = word[14:12];
	rd = word[11:7];
	is_op = (opcode == 7'b0110011);
	a = model_regs[word[19:15]];
	b = is_op ? model_regs[word[24:20]] : {{20{word[31]}}, word[31:20]}; // rs2 or I immediate.
	data = 32'd0;
	if (opcode == 7'b0110111) begin
		data = {word[31:12], 12'h000};
	end else if (is_op || opcode == 7'b0010011) begin
		case (funct3)
			3'b000: data = (is_op && word[30]) ? a - b : a + b;
			3'b001: data = a << b[4:0];
			3'b010: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: data = (a < b) ? 32'd1 : 32'd0;
			3'b100: data = a ^ b;
			3'b101: begin
				if (word[30])
					data = $signed(a) >>> b[4:0];
				else
					data = a >> b[4:0];
			end
			3'b110: data = a | b;
			default: data = a & b;
		endcase
	end else begin
		rd = 5'd0; // other opcodes retire as a no-op.
	end
	if (rd == 5'd0)
		data = 32'd0;
	else
		model_regs[rd] = data;
endtask

`endif

//--- sim/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

	localparam int num_instr = 300;
	localparam int timeout_cycles = num_instr * 20;
	localparam int drain_cycles = 8;

	logic clk;
	logic reset;
	logic instr_valid;
	logic [31:0] instr;
	logic instr_ready;
	logic commit_valid;
	logic [4:0] commit_rd;
	logic [31:0] commit_data;

	logic [31:0] program_words [num_instr];
	logic [4:0] expected_rd [$];
	logic [31:0] expected_data [$];
	int cycles, released, sent, accepted, commits, drain;
	int value_errors, other_errors;

	`include "cpu_model.svh"

	cpu #(.rob_size(8), .alu_rs_size(4), .iq_depth(4)) DUT (.*);

	always #2 clk = ~clk;

	// registers stay within x0 to x7, so most words depend on recent ones.
	function automatic logic [31:0] random_instr();
		logic [4:0] rd, rs1, rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic alt;
		rd = 5'($urandom % 8);
		rs1 = 5'($urandom % 8);
		rs2 = 5'($urandom % 8);
		f3 = 3'($urandom % 8);
		imm = 12'($urandom);
		alt = 1'($urandom % 2);
		case ($urandom % 3)
			0: return {(alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
				rs2, rs1, f3, rd, 7'b0110011};
			1: begin
				if (f3 == 3'b001)
					imm = {7'h00, imm[4:0]};
				else if (f3 == 3'b101)
					imm = {alt ? 7'h20 : 7'h00, imm[4:0]}; // srai sets bit 30.
				return {imm, rs1, f3, rd, 7'b0010011};
			end
			default: return {imm, 8'($urandom), rd, 7'b0110111};
		endcase
	endfunction

	task automatic end_run();
		if (commits != accepted || accepted != num_instr || expected_rd.size() != 0) begin
			$display("committed %0d words but %0d were accepted", commits, accepted);
			other_errors++;
		end
		$display("errors: %0d wrong values, %0d other; %0d words accepted, %0d committed",
			value_errors, other_errors, accepted, commits);
		if (value_errors + other_errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	endtask

	initial begin
		void'($urandom(33060));
		clk = 1'b0;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = 32'd0;
		cycles = 0;
		released = 0;
		sent = 0;
		accepted = 0;
		commits = 0;
		drain = 0;
		value_errors = 0;
		other_errors = 0;
		clear_model_regs();
		foreach (program_words[i])
			program_words[i] = random_instr();
	end

	always @(posedge clk) begin
		logic [4:0] rd, exp_rd;
		logic [31:0] data, exp_data;
		logic took;
		cycles++;
		took = 1'b0;
		if (reset) begin
			if (cycles > 1 && commit_valid !== 1'b0) begin
				$display("commit_valid is high during reset at cycle %0d", cycles);
				other_errors++;
			end
			if (cycles == 3)
				reset <= 1'b0;
		end else begin
			released++;
			if (released <= 2 && commit_valid !== 1'b0) begin
				$display("commit_valid is high on the first cycle after reset");
				other_errors++;
			end
			if (instr_valid && instr_ready) begin
				execute_word(instr, rd, data);
				expected_rd.push_back(rd);
				expected_data.push_back(data);
				accepted++;
				took = 1'b1;
			end
			if (commit_valid) begin
				commits++;
				if (expected_rd.size() == 0) begin
					$display("commit %0d arrived with no accepted word left to match", commits);
					other_errors++;
				end else begin
					exp_rd = expected_rd.pop_front();
					exp_data = expected_data.pop_front();
					if (commit_rd !== exp_rd) begin
						$display("ERR commit_rd #%0d expected x%0d actual x%0d",
							commits, exp_rd, commit_rd);
						value_errors++;
					end
					if (commit_data !== exp_data) begin
						$display("ERR commit_data #%0d expected %h actual %h",
							commits, exp_data, commit_data);
						value_errors++;
					end
				end
			end
			// a word on offer stays put until the queue takes it.
			if (!instr_valid || took) begin
				if (sent < num_instr && $urandom % 4 != 0) begin
					instr_valid <= 1'b1;
					instr <= program_words[sent];
					sent++;
				end else begin
					instr_valid <= 1'b0;
				end
			end
			if (commits >= num_instr)
				drain++; // extra commits in this window find an empty queue.
		end
		if (drain == drain_cycles) begin
			end_run();
		end else if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles with %0d of %0d words committed",
				cycles, commits, num_instr);
			$display("errors: %0d wrong values, %0d other; %0d words accepted, %0d committed",
				value_errors, other_errors, accepted, commits);
			$display(">>> FAIL");
			$finish;
		end
	end

endmodule : tb_cpu

//--- vlog.f
+incdir+sim
source/rv32i_types.sv
source/circular_q.sv
source/decoder.sv
source/reservation_station.sv
source/alu.sv
source/reorder_buffer.sv
source/regfile.sv
source/cpu.sv
sim/tb_cpu.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cpu -f vlog.f -o tb_cpu

./obj_dir/tb_cpu | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
